// File: verilog/attrib_interp_pkg.sv
////////////////////////////////////////
// Attributes are signed Q16.16 and every sum and product wraps modulo 2^32
// Latencies are in aclk cycles with no back-pressure on the pixel stream
////////////////////////////////////////
package attrib_interp_pkg;

    ////////////////////////////////////////
    // Fixed-point attribute format
    ////////////////////////////////////////
    localparam int ATTR_INT_BITS  = 16;
    localparam int ATTR_FRAC_BITS = 16;
    localparam int ATTR_WIDTH     = ATTR_INT_BITS + ATTR_FRAC_BITS;

    typedef logic signed [ATTR_WIDTH-1:0] attr_t;

    // One word per interpolated attribute
    localparam int NUM_ATTRIBS = 7;

    typedef attr_t [NUM_ATTRIBS-1:0] attr_vec_t;

    ////////////////////////////////////////
    // Attribute slots in attr_vec_t
    ////////////////////////////////////////
    localparam int ATTR_TEX0_S  = 0;
    localparam int ATTR_TEX0_T  = 1;
    localparam int ATTR_DEPTH_Z = 2;
    localparam int ATTR_COLOR_R = 3;
    localparam int ATTR_COLOR_G = 4;
    localparam int ATTR_COLOR_B = 5;
    localparam int ATTR_COLOR_A = 6;

    ////////////////////////////////////////
    // Pipeline depth per stage
    ////////////////////////////////////////
    localparam int DECODE_LATENCY  = 1;
    localparam int EXECUTE_LATENCY = 2;
    localparam int RESULT_LATENCY  = 1;

    // Input valid to output valid
    localparam int INTERP_LATENCY  = DECODE_LATENCY + EXECUTE_LATENCY + RESULT_LATENCY;

endpackage

// File: verilog/attrib_product_if.sv
////////////////////////////////////////
// Decoded pixel with its products and bases, valid only
////////////////////////////////////////
interface attrib_product_if #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
);
    import attrib_interp_pkg::*;

    // Pixel sideband
    logic                        valid;
    logic                        last;
    logic                        keep;
    logic [SCREEN_POS_WIDTH-1:0] spx;
    logic [SCREEN_POS_WIDTH-1:0] spy;
    logic [INDEX_WIDTH-1:0]      index;

    // Per attribute terms of the plane equation
    attr_vec_t                   prod_x;
    attr_vec_t                   prod_y;
    attr_vec_t                   base;

    modport producer (
        output valid, last, keep,
        output spx, spy, index,
        output prod_x, prod_y, base
    );

    modport consumer (
        input valid, last, keep,
        input spx, spy, index,
        input prod_x, prod_y, base
    );

endinterface

// File: verilog/attrib_value_if.sv
////////////////////////////////////////
// Interpolated pixel, valid only
////////////////////////////////////////
interface attrib_value_if #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
);
    import attrib_interp_pkg::*;

    logic                        valid;
    logic                        last;
    logic                        keep;
    logic [SCREEN_POS_WIDTH-1:0] spx;
    logic [SCREEN_POS_WIDTH-1:0] spy;
    logic [INDEX_WIDTH-1:0]      index;

    // Final attribute values
    attr_vec_t                   value;

    modport producer (
        output valid, last, keep,
        output spx, spy, index,
        output value
    );

    modport consumer (
        input valid, last, keep,
        input spx, spy, index,
        input value
    );

endinterface

// File: verilog/attrib_decode.sv
////////////////////////////////////////
// SCREEN_POS_WIDTH must stay below the attribute width
// Products keep only their low word and wrap silently
////////////////////////////////////////
module attrib_decode #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
) (
    input  logic                         aclk,
    input  logic                         rst,

    // Pixel stream from the rasterizer
    input  logic                         in_valid,
    input  logic                         in_last,
    input  logic                         in_keep,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_bbx,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_bby,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_spx,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_spy,
    input  logic [INDEX_WIDTH-1:0]       in_index,

    // Triangle attributes, sampled with the pixel
    input  attrib_interp_pkg::attr_vec_t attr_base,
    input  attrib_interp_pkg::attr_vec_t attr_inc_x,
    input  attrib_interp_pkg::attr_vec_t attr_inc_y,

    attrib_product_if.producer           prod
);
    import attrib_interp_pkg::*;

    attr_t     bbx_int;
    attr_t     bby_int;
    attr_vec_t prod_x_c;
    attr_vec_t prod_y_c;

    // Bounding box offsets are unsigned integers
    assign bbx_int = attr_t'({{(ATTR_WIDTH - SCREEN_POS_WIDTH){1'b0}}, in_bbx});
    assign bby_int = attr_t'({{(ATTR_WIDTH - SCREEN_POS_WIDTH){1'b0}}, in_bby});

    // Integer times Q16.16 is still Q16.16
    // Only the low word is kept
    always_comb begin
        for (int i = 0; i < NUM_ATTRIBS; i++) begin
            prod_x_c[i] = attr_t'(bbx_int * attr_inc_x[i]);
            prod_y_c[i] = attr_t'(bby_int * attr_inc_y[i]);
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        prod.last   <= in_last;
        prod.keep   <= in_keep;
        prod.spx    <= in_spx;
        prod.spy    <= in_spy;
        prod.index  <= in_index;
        prod.prod_x <= prod_x_c;
        prod.prod_y <= prod_y_c;
        prod.base   <= attr_base;
    end

    // Stream valid must be known on both sides of the input register
    valid_known_a: assert property (@(posedge aclk) disable iff (rst)
        !$isunknown({in_valid, prod.valid}))
        else $error("unknown valid in pixel stream");

endmodule

// File: verilog/attrib_execute.sv
////////////////////////////////////////
// Two adder stages, all sums wrap modulo 2^32
////////////////////////////////////////
module attrib_execute #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
) (
    input  logic               aclk,
    input  logic               rst,
    attrib_product_if.consumer prod,
    attrib_value_if.producer   value
);
    import attrib_interp_pkg::*;

    // First stage registers
    logic                        s1_valid;
    logic                        s1_last;
    logic                        s1_keep;
    logic [SCREEN_POS_WIDTH-1:0] s1_spx;
    logic [SCREEN_POS_WIDTH-1:0] s1_spy;
    logic [INDEX_WIDTH-1:0]      s1_index;
    attr_vec_t                   s1_sum_xy;
    attr_vec_t                   s1_base;

    always_ff @(posedge aclk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            value.valid <= 1'b0;
        end else begin
            s1_valid    <= prod.valid;
            value.valid <= s1_valid;
        end
    end

    ////////////////////////////////////////
    // Stage 1 sums the two products
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        s1_last  <= prod.last;
        s1_keep  <= prod.keep;
        s1_spx   <= prod.spx;
        s1_spy   <= prod.spy;
        s1_index <= prod.index;
        s1_base  <= prod.base;
        for (int i = 0; i < NUM_ATTRIBS; i++) begin
            s1_sum_xy[i] <= prod.prod_x[i] + prod.prod_y[i];
        end
    end

    ////////////////////////////////////////
    // Stage 2 adds the base
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        value.last  <= s1_last;
        value.keep  <= s1_keep;
        value.spx   <= s1_spx;
        value.spy   <= s1_spy;
        value.index <= s1_index;
        for (int i = 0; i < NUM_ATTRIBS; i++) begin
            value.value[i] <= s1_sum_xy[i] + s1_base[i];
        end
    end

endmodule

// File: verilog/attrib_result.sv
////////////////////////////////////////
// in_valid must be the top-level input valid
// so the counter covers the whole pipeline
////////////////////////////////////////
module attrib_result #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
) (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         in_valid,
    attrib_value_if.consumer             value,

    // Interpolated pixel stream
    output logic                         out_valid,
    output logic                         out_last,
    output logic                         out_keep,
    output logic [SCREEN_POS_WIDTH-1:0]  out_spx,
    output logic [SCREEN_POS_WIDTH-1:0]  out_spy,
    output logic [INDEX_WIDTH-1:0]       out_index,
    output attrib_interp_pkg::attr_vec_t out_attr,

    output logic                         pixel_in_pipeline
);
    import attrib_interp_pkg::*;

    localparam int CNT_WIDTH = $clog2(INTERP_LATENCY + 1);

    logic [CNT_WIDTH-1:0] pixel_cnt;

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= value.valid;
        end
    end

    always_ff @(posedge aclk) begin
        out_last  <= value.last;
        out_keep  <= value.keep;
        out_spx   <= value.spx;
        out_spy   <= value.spy;
        out_index <= value.index;
        out_attr  <= value.value;
    end

    ////////////////////////////////////////
    // Pixels in flight
    ////////////////////////////////////////
    // One in and one out in the same cycle leaves the count alone
    always_ff @(posedge aclk) begin
        if (rst) begin
            pixel_cnt <= '0;
        end else if (in_valid && !out_valid) begin
            pixel_cnt <= pixel_cnt + 1'b1;
        end else if (!in_valid && out_valid) begin
            pixel_cnt <= pixel_cnt - 1'b1;
        end
    end

    assign pixel_in_pipeline = (pixel_cnt != '0);

    // Pipeline depth bounds the pixels in flight
    cnt_max_a: assert property (@(posedge aclk) disable iff (rst)
        pixel_cnt <= INTERP_LATENCY)
        else $error("more pixels in flight than pipeline stages");

    // A pixel leaving with none counted means a valid was lost or invented
    cnt_underflow_a: assert property (@(posedge aclk) disable iff (rst)
        (pixel_cnt == '0) |-> !out_valid)
        else $error("output pixel with empty pipeline");

endmodule

// File: verilog/attrib_interpolator.sv
////////////////////////////////////////
// No ready signal, a pixel may enter every cycle
// Output follows input by INTERP_LATENCY cycles in order
////////////////////////////////////////
module attrib_interpolator #(
    parameter int SCREEN_POS_WIDTH = 11,
    parameter int INDEX_WIDTH      = 32
) (
    input  logic                         aclk,
    input  logic                         rst,

    // Pixel stream
    input  logic                         in_valid,
    input  logic                         in_last,
    input  logic                         in_keep,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_bbx,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_bby,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_spx,
    input  logic [SCREEN_POS_WIDTH-1:0]  in_spy,
    input  logic [INDEX_WIDTH-1:0]       in_index,

    // Triangle attributes
    input  attrib_interp_pkg::attr_vec_t attr_base,
    input  attrib_interp_pkg::attr_vec_t attr_inc_x,
    input  attrib_interp_pkg::attr_vec_t attr_inc_y,

    // Interpolated pixel stream
    output logic                         out_valid,
    output logic                         out_last,
    output logic                         out_keep,
    output logic [SCREEN_POS_WIDTH-1:0]  out_spx,
    output logic [SCREEN_POS_WIDTH-1:0]  out_spy,
    output logic [INDEX_WIDTH-1:0]       out_index,
    output attrib_interp_pkg::attr_vec_t out_attr,

    output logic                         pixel_in_pipeline
);

    attrib_product_if #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) product_bus ();

    attrib_value_if #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) value_bus ();

    attrib_decode #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) i_attrib_decode (
        .aclk       (aclk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_keep    (in_keep),
        .in_bbx     (in_bbx),
        .in_bby     (in_bby),
        .in_spx     (in_spx),
        .in_spy     (in_spy),
        .in_index   (in_index),
        .attr_base  (attr_base),
        .attr_inc_x (attr_inc_x),
        .attr_inc_y (attr_inc_y),
        .prod       (product_bus.producer)
    );

    attrib_execute #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) i_attrib_execute (
        .aclk  (aclk),
        .rst   (rst),
        .prod  (product_bus.consumer),
        .value (value_bus.producer)
    );

    // Counts from the top-level valid, not the decoded one
    attrib_result #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) i_attrib_result (
        .aclk              (aclk),
        .rst               (rst),
        .in_valid          (in_valid),
        .value             (value_bus.consumer),
        .out_valid         (out_valid),
        .out_last          (out_last),
        .out_keep          (out_keep),
        .out_spx           (out_spx),
        .out_spy           (out_spy),
        .out_index         (out_index),
        .out_attr          (out_attr),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

endmodule

// File: verif/tb_attrib_model.svh
////////////////////////////////////////
// Included inside the testbench module after the package import
// Expects SCREEN_POS_WIDTH and INDEX_WIDTH as localparams
////////////////////////////////////////
`ifndef TB_ATTRIB_MODEL_SVH
`define TB_ATTRIB_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'd4;

function automatic logic step_lfsr();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out_bit ? 32'h80200003 : 32'h0);
    return out_bit;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r[i] = step_lfsr();
    end
    return r;
endfunction

// Small signed increment, about +-0.5 in Q16.16
function automatic attr_t rand_inc();
    logic [31:0] r;
    r = rand_bits(16);
    return attr_t'({{16{r[15]}}, r[15:0]});
endfunction

// Plane equation, truncated to the low word
function automatic attr_t plane_value(input attr_t base, input attr_t inc_x,
                                      input attr_t inc_y,
                                      input logic [SCREEN_POS_WIDTH-1:0] bbx,
                                      input logic [SCREEN_POS_WIDTH-1:0] bby);
    longint sum;
    sum = longint'(base) + longint'(inc_x) * longint'(bbx)
          + longint'(inc_y) * longint'(bby);
    return attr_t'(sum[31:0]);
endfunction

// One expected output pixel
typedef struct {
    int unsigned                 due;
    logic                        last;
    logic                        keep;
    logic [SCREEN_POS_WIDTH-1:0] spx;
    logic [SCREEN_POS_WIDTH-1:0] spy;
    logic [INDEX_WIDTH-1:0]      index;
    attr_vec_t                   attr;
} exp_pixel_t;

exp_pixel_t exp_q[$];

`endif

// File: verif/tb_attrib_interpolator.sv
////////////////////////////////////////
// Checks values, order, latency and in-flight flag from a fixed seed
////////////////////////////////////////
module tb_attrib_interpolator;
    timeunit 1ns;
    timeprecision 1ps;
    import attrib_interp_pkg::*;

    localparam int SCREEN_POS_WIDTH = 11;
    localparam int INDEX_WIDTH      = 32;
    localparam int RESET_CYCLES     = 8;
    localparam int MAX_GAP          = 3;
    localparam int NUM_PIXELS       = 20 + 40 + 20;
    localparam int WATCHDOG_CYCLES  = NUM_PIXELS * (MAX_GAP + 1) + 4 * RESET_CYCLES
                                      + INTERP_LATENCY + 50;

    `include "tb_attrib_model.svh"

    logic                        aclk;
    logic                        rst;
    logic                        in_valid;
    logic                        in_last;
    logic                        in_keep;
    logic [SCREEN_POS_WIDTH-1:0] in_bbx;
    logic [SCREEN_POS_WIDTH-1:0] in_bby;
    logic [SCREEN_POS_WIDTH-1:0] in_spx;
    logic [SCREEN_POS_WIDTH-1:0] in_spy;
    logic [INDEX_WIDTH-1:0]      in_index;
    attr_vec_t                   attr_base;
    attr_vec_t                   attr_inc_x;
    attr_vec_t                   attr_inc_y;
    logic                        out_valid;
    logic                        out_last;
    logic                        out_keep;
    logic [SCREEN_POS_WIDTH-1:0] out_spx;
    logic [SCREEN_POS_WIDTH-1:0] out_spy;
    logic [INDEX_WIDTH-1:0]      out_index;
    attr_vec_t                   out_attr;
    logic                        pixel_in_pipeline;

    int          value_errors    = 0;
    int          sideband_errors = 0;
    int          timing_errors   = 0;
    int unsigned cycle           = 0;

    // Reset level seen at the previous falling edge
    logic        rst_prev        = 1'b0;

    attrib_interpolator #(
        .SCREEN_POS_WIDTH (SCREEN_POS_WIDTH),
        .INDEX_WIDTH      (INDEX_WIDTH)
    ) i_attrib_interpolator (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic drive_pixel();
        attr_vec_t base;
        attr_vec_t inc_x;
        attr_vec_t inc_y;
        logic [31:0] r;
        for (int i = 0; i < NUM_ATTRIBS; i++) begin
            base[i]  = attr_t'(rand_bits(32));
            inc_x[i] = rand_inc();
            inc_y[i] = rand_inc();
        end
        r = rand_bits(2);
        @(posedge aclk);
        in_valid   <= 1'b1;
        in_last    <= r[0];
        in_keep    <= r[1];
        in_bbx     <= SCREEN_POS_WIDTH'(rand_bits(SCREEN_POS_WIDTH));
        in_bby     <= SCREEN_POS_WIDTH'(rand_bits(SCREEN_POS_WIDTH));
        in_spx     <= SCREEN_POS_WIDTH'(rand_bits(SCREEN_POS_WIDTH));
        in_spy     <= SCREEN_POS_WIDTH'(rand_bits(SCREEN_POS_WIDTH));
        in_index   <= rand_bits(32);
        attr_base  <= base;
        attr_inc_x <= inc_x;
        attr_inc_y <= inc_y;
    endtask

    task automatic idle_cycle();
        @(posedge aclk);
        in_valid <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge aclk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst <= 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (2) @(posedge aclk);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected, inout int errors);
        assert (got === expected) else begin
            errors++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // Attribute name for error lines
    function automatic string attr_label(input int i);
        case (i)
            ATTR_TEX0_S:  return "tex0_s";
            ATTR_TEX0_T:  return "tex0_t";
            ATTR_DEPTH_Z: return "depth_z";
            ATTR_COLOR_R: return "color_r";
            ATTR_COLOR_G: return "color_g";
            ATTR_COLOR_B: return "color_b";
            ATTR_COLOR_A: return "color_a";
            default:      return $sformatf("%0d", i);
        endcase
    endfunction

    ////////////////////////////////////////
    // Monitor samples between edges
    ////////////////////////////////////////
    always @(negedge aclk) begin
        exp_pixel_t exp_pix;
        cycle++;
        if (rst) begin
            exp_q.delete();
            // DUT has taken reset at the last rising edge
            if (rst_prev) begin
                assert (out_valid === 1'b0 && pixel_in_pipeline === 1'b0) else begin
                    timing_errors++;
                    $display("out_valid or pixel_in_pipeline high at %0t during reset",
                             $time);
                end
            end
        end else begin
            // Queue holds exactly the pixels in flight
            assert (pixel_in_pipeline === (exp_q.size() != 0)) else begin
                timing_errors++;
                $display("[ERROR] %0t pixel_in_pipeline got %b expected %b", $time,
                         pixel_in_pipeline, exp_q.size() != 0);
            end
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                exp_pix = exp_q.pop_front();
                assert (out_valid === 1'b1) else begin
                    timing_errors++;
                    $display("Pixel due at %0t did not appear on out_valid", $time);
                end
                if (out_valid === 1'b1) begin
                    compare_field("out_last", 32'(out_last), 32'(exp_pix.last), sideband_errors);
                    compare_field("out_keep", 32'(out_keep), 32'(exp_pix.keep), sideband_errors);
                    compare_field("out_spx", 32'(out_spx), 32'(exp_pix.spx), sideband_errors);
                    compare_field("out_spy", 32'(out_spy), 32'(exp_pix.spy), sideband_errors);
                    compare_field("out_index", out_index, exp_pix.index, sideband_errors);
                    for (int i = 0; i < NUM_ATTRIBS; i++) begin
                        compare_field($sformatf("out_attr[%s]", attr_label(i)), out_attr[i],
                                      exp_pix.attr[i], value_errors);
                    end
                end
            end else begin
                assert (out_valid === 1'b0) else begin
                    timing_errors++;
                    $display("out_valid high at %0t with no pixel due", $time);
                end
            end
            // Pixel visible now is taken at the next edge
            if (in_valid === 1'b1) begin
                exp_pix.due   = cycle + INTERP_LATENCY;
                exp_pix.last  = in_last;
                exp_pix.keep  = in_keep;
                exp_pix.spx   = in_spx;
                exp_pix.spy   = in_spy;
                exp_pix.index = in_index;
                for (int i = 0; i < NUM_ATTRIBS; i++) begin
                    exp_pix.attr[i] = plane_value(attr_base[i], attr_inc_x[i],
                                                  attr_inc_y[i], in_bbx, in_bby);
                end
                exp_q.push_back(exp_pix);
            end
        end
        rst_prev = rst;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        int gap;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_keep    = 1'b0;
        in_bbx     = '0;
        in_bby     = '0;
        in_spx     = '0;
        in_spy     = '0;
        in_index   = '0;
        attr_base  = '0;
        attr_inc_x = '0;
        attr_inc_y = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst <= 1'b0;
        idle_cycle();

        // Back-to-back burst
        repeat (20) drive_pixel();
        drain();

        // Random gaps between pixels
        repeat (40) begin
            drive_pixel();
            gap = int'(rand_bits(2));
            repeat (gap) idle_cycle();
        end
        drain();

        // Reset in the middle of a stream
        repeat (10) drive_pixel();
        apply_reset();
        idle_cycle();
        repeat (10) drive_pixel();
        drain();

        assert (pixel_in_pipeline === 1'b0 && out_valid === 1'b0) else begin
            timing_errors++;
            $display("Pipeline not empty after the stream drained");
        end
        $display("Errors: value %0d, sideband %0d, timing %0d",
                 value_errors, sideband_errors, timing_errors);
        if (value_errors + sideband_errors + timing_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: attrib_interpolator.f
+incdir+verif
verilog/attrib_interp_pkg.sv
verilog/attrib_product_if.sv
verilog/attrib_value_if.sv
verilog/attrib_decode.sv
verilog/attrib_execute.sv
verilog/attrib_result.sv
verilog/attrib_interpolator.sv
verif/tb_attrib_interpolator.sv

// File: Makefile
SRCS := $(shell grep -v '^+' attrib_interpolator.f)
BIN  := obj_dir/Vtb_attrib_interpolator

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verif/tb_attrib_model.svh attrib_interpolator.f
	verilator --binary --timing --assert -f attrib_interpolator.f \
		--top-module tb_attrib_interpolator -o Vtb_attrib_interpolator

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
